//--- source/rp_pkg.sv
// Shared widths and sample types for the ADC/DAC data path
// APB request/response structs and region map
// Identification word and DAC idle code
package rp_pkg;

  // Channel count and sample widths
  localparam int CHN_NUM = 2;
  localparam int ADC_DW  = 16;
  localparam int DAC_DW  = 14;

  typedef logic signed [ADC_DW-1:0] adc_t;
  typedef logic signed [DAC_DW-1:0] dac_t;
  typedef logic        [DAC_DW-1:0] dac_code_t;

  // Auxiliary PDM outputs
  localparam int PDM_NUM = 4;
  localparam int PDM_DW  = 8;

  typedef logic [PDM_DW-1:0] pdm_t;

  // APB address split, region on top of byte offset
  localparam int APB_AW = 20;
  localparam int APB_OW = 16;
  localparam int APB_DW = 32;

  typedef logic [APB_AW-1:0]        apb_addr_t;
  typedef logic [APB_OW-1:0]        apb_ofs_t;
  typedef logic [APB_AW-APB_OW-1:0] region_t;
  typedef logic [APB_DW-1:0]        apb_data_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Region numbers
  localparam region_t REG_ID  = region_t'(0);
  localparam region_t REG_PDM = region_t'(1);
  localparam region_t REG_CLB = region_t'(3);
  localparam region_t REG_DAC = region_t'(4);
  localparam region_t REG_ADC = region_t'(5);

  // Board identification
  localparam apb_data_t ID_VALUE = 32'h5250_0102;

  // DAC pin code of a zero sample
  localparam dac_code_t DAC_IDLE = 14'h1FFF;

endpackage

//--- source/adc_frontend.sv
// ADC input registers for both channels
// Negative-slope code to two's complement conversion
`timescale 1ns/1ps

module adc_frontend (
  input  logic                                           adc_clk,
  input  logic                                           top_rst,
  input  logic [rp_pkg::CHN_NUM-1:0][rp_pkg::ADC_DW-1:0] adc_dat_i,
  output rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0]             adc_o
);

  // Raw pin words, one register stage
  logic [rp_pkg::CHN_NUM-1:0][rp_pkg::ADC_DW-1:0] adc_raw;

  // Reset to the pin code of a zero sample
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= {rp_pkg::CHN_NUM{1'b0, {(rp_pkg::ADC_DW-1){1'b1}}}};
    end else begin
      adc_raw <= adc_dat_i;
    end
  end

  // Keep sign bit, invert magnitude bits
  for (genvar i = 0; i < rp_pkg::CHN_NUM; i++) begin : g_conv
    assign adc_o[i] = {adc_raw[i][rp_pkg::ADC_DW-1], ~adc_raw[i][rp_pkg::ADC_DW-2:0]};
  end

endmodule

//--- source/calib.sv
// Calibration block with APB offset registers
// Saturating offset addition on ADC and DAC sample paths
`timescale 1ns/1ps

module calib (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  input  rp_pkg::apb_req_t                   apb_req_i,
  output rp_pkg::apb_rsp_t                   apb_rsp_o,
  input  rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0] adc_i,
  output rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0] adc_o,
  input  rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0] dac_i,
  output rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0] dac_o
);

  localparam int AW = rp_pkg::ADC_DW;
  localparam int DW = rp_pkg::DAC_DW;

  rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0] adc_ofs;
  rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0] dac_ofs;
  rp_pkg::apb_ofs_t                   ofs;
  logic                               wr_en;
  rp_pkg::apb_data_t                  rdata;

  // Sum one bit wider, clamp on overflow
  function automatic rp_pkg::adc_t adc_sat(rp_pkg::adc_t smp, rp_pkg::adc_t add);
    logic [AW:0] sum;
    sum = {smp[AW-1], smp} + {add[AW-1], add};
    adc_sat = (sum[AW] != sum[AW-1]) ? {sum[AW], {(AW-1){~sum[AW]}}} : sum[AW-1:0];
  endfunction

  function automatic rp_pkg::dac_t dac_sat(rp_pkg::dac_t smp, rp_pkg::dac_t add);
    logic [DW:0] sum;
    sum = {smp[DW-1], smp} + {add[DW-1], add};
    dac_sat = (sum[DW] != sum[DW-1]) ? {sum[DW], {(DW-1){~sum[DW]}}} : sum[DW-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // Offset registers, ADC first then DAC, 4 bytes apart
  ////////////////////////////////////////////////////////////

  assign ofs   = apb_req_i.paddr[rp_pkg::APB_OW-1:0];
  assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_ofs <= '0;
      dac_ofs <= '0;
    end else if (wr_en) begin
      for (int i = 0; i < rp_pkg::CHN_NUM; i++) begin
        if (ofs == rp_pkg::apb_ofs_t'(4*i)) adc_ofs[i] <= apb_req_i.pwdata[AW-1:0];
        if (ofs == rp_pkg::apb_ofs_t'(4*(rp_pkg::CHN_NUM+i))) dac_ofs[i] <= apb_req_i.pwdata[DW-1:0];
      end
    end
  end

  // Readback sign-extended
  always_comb begin
    rdata = '0;
    for (int i = 0; i < rp_pkg::CHN_NUM; i++) begin
      if (ofs == rp_pkg::apb_ofs_t'(4*i)) rdata = {{(rp_pkg::APB_DW-AW){adc_ofs[i][AW-1]}}, adc_ofs[i]};
      if (ofs == rp_pkg::apb_ofs_t'(4*(rp_pkg::CHN_NUM+i))) begin
        rdata = {{(rp_pkg::APB_DW-DW){dac_ofs[i][DW-1]}}, dac_ofs[i]};
      end
    end
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = apb_req_i.psel & apb_req_i.penable;
  assign apb_rsp_o.pslverr = 1'b0;

  ////////////////////////////////////////////////////////////
  // Sample paths, one register stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_o <= '0;
      dac_o <= '0;
    end else begin
      for (int i = 0; i < rp_pkg::CHN_NUM; i++) begin
        adc_o[i] <= adc_sat(adc_i[i], adc_ofs[i]);
        dac_o[i] <= dac_sat(dac_i[i], dac_ofs[i]);
      end
    end
  end

endmodule

//--- source/dac_backend.sv
// DAC output registers and two's complement to DAC code conversion
// Channel interleave onto one DAC bus with a toggling select
`timescale 1ns/1ps

module dac_backend (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  input  rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0] dac_i,
  output rp_pkg::dac_code_t                  dac_dat_o,
  output logic                               dac_sel_o
);

  localparam int DW = rp_pkg::DAC_DW;

  // Per-channel pin codes
  rp_pkg::dac_code_t [rp_pkg::CHN_NUM-1:0] dac_code;

  // Channel select, 0 is channel 0
  logic dac_sel;

  ////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////

  // Sign bit kept, magnitude inverted for negative slope
  // Idle code is mid scale
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_code <= {rp_pkg::CHN_NUM{rp_pkg::DAC_IDLE}};
    end else begin
      for (int i = 0; i < rp_pkg::CHN_NUM; i++) begin
        dac_code[i] <= {dac_i[i][DW-1], ~dac_i[i][DW-2:0]};
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Interleave
  ////////////////////////////////////////////////////////////

  // Flips every cycle
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_sel <= 1'b0;
    end else begin
      dac_sel <= ~dac_sel;
    end
  end

  // Bus follows select
  assign dac_dat_o = dac_code[dac_sel];
  assign dac_sel_o = dac_sel;

endmodule

//--- source/sys_regs.sv
// System register block on APB
// Identification, PDM levels, DAC levels and calibrated ADC readback
`timescale 1ns/1ps

module sys_regs (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  input  rp_pkg::apb_req_t                   apb_req_i,
  output rp_pkg::apb_rsp_t                   apb_rsp_o,
  input  rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0] adc_i,
  output rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0] dac_o,
  output rp_pkg::pdm_t [rp_pkg::PDM_NUM-1:0] pdm_o
);

  localparam int AW = rp_pkg::ADC_DW;
  localparam int DW = rp_pkg::DAC_DW;
  localparam int PW = rp_pkg::PDM_DW;
  localparam int BW = rp_pkg::APB_DW;

  rp_pkg::region_t                    region;
  rp_pkg::apb_ofs_t                   ofs;
  logic                               wr_en;
  rp_pkg::apb_data_t                  rdata;

  // Level registers
  rp_pkg::pdm_t [rp_pkg::PDM_NUM-1:0] pdm_lvl;
  rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0] dac_lvl;

  // Address split
  assign region = apb_req_i.paddr[rp_pkg::APB_AW-1:rp_pkg::APB_OW];
  assign ofs    = apb_req_i.paddr[rp_pkg::APB_OW-1:0];
  assign wr_en  = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;

  ////////////////////////////////////////////////////////////
  // Writes, end of access cycle
  ////////////////////////////////////////////////////////////

  // ID and ADC regions are read-only
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      pdm_lvl <= '0;
      dac_lvl <= '0;
    end else if (wr_en) begin
      for (int i = 0; i < rp_pkg::PDM_NUM; i++) begin
        if (region == rp_pkg::REG_PDM && ofs == rp_pkg::apb_ofs_t'(4*i)) begin
          pdm_lvl[i] <= apb_req_i.pwdata[PW-1:0];
        end
      end
      for (int i = 0; i < rp_pkg::CHN_NUM; i++) begin
        if (region == rp_pkg::REG_DAC && ofs == rp_pkg::apb_ofs_t'(4*i)) begin
          dac_lvl[i] <= apb_req_i.pwdata[DW-1:0];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux, unused offsets give zero
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (region)
      rp_pkg::REG_ID: begin
        if (ofs == '0) rdata = rp_pkg::ID_VALUE;
      end
      rp_pkg::REG_PDM: begin
        // Levels are unsigned
        for (int i = 0; i < rp_pkg::PDM_NUM; i++) begin
          if (ofs == rp_pkg::apb_ofs_t'(4*i)) rdata = {{(BW-PW){1'b0}}, pdm_lvl[i]};
        end
      end
      rp_pkg::REG_DAC: begin
        for (int i = 0; i < rp_pkg::CHN_NUM; i++) begin
          if (ofs == rp_pkg::apb_ofs_t'(4*i)) rdata = {{(BW-DW){dac_lvl[i][DW-1]}}, dac_lvl[i]};
        end
      end
      rp_pkg::REG_ADC: begin
        // Latest calibrated sample, sign-extended
        for (int i = 0; i < rp_pkg::CHN_NUM; i++) begin
          if (ofs == rp_pkg::apb_ofs_t'(4*i)) rdata = {{(BW-AW){adc_i[i][AW-1]}}, adc_i[i]};
        end
      end
      default: ;
    endcase
  end

  // No wait states
  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = apb_req_i.psel & apb_req_i.penable;
  assign apb_rsp_o.pslverr = 1'b0;

  assign dac_o = dac_lvl;
  assign pdm_o = pdm_lvl;

endmodule

//--- source/pdm.sv
// Four-channel first-order pulse-density modulator
// Output density is level/256 per channel
`timescale 1ns/1ps

module pdm (
  input  logic                               adc_clk,
  input  logic                               top_rst,
  input  rp_pkg::pdm_t [rp_pkg::PDM_NUM-1:0] level_i,
  output logic [rp_pkg::PDM_NUM-1:0]         pdm_o
);

  localparam int PW = rp_pkg::PDM_DW;

  // Accumulators, wrap at 256
  rp_pkg::pdm_t [rp_pkg::PDM_NUM-1:0] acc;

  // Next sum with carry on top
  logic [rp_pkg::PDM_NUM-1:0][PW:0] sum;

  ////////////////////////////////////////////////////////////
  // Accumulate and emit carry
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < rp_pkg::PDM_NUM; i++) begin
      sum[i] = {1'b0, acc[i]} + {1'b0, level_i[i]};
    end
  end

  // Carry count over 256 cycles equals level
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      acc   <= '0;
      pdm_o <= '0;
    end else begin
      for (int i = 0; i < rp_pkg::PDM_NUM; i++) begin
        acc[i]   <= sum[i][PW-1:0];
        pdm_o[i] <= sum[i][PW];
      end
    end
  end

endmodule

//--- source/apb_region_decoder.sv
// APB region decoder
// Routes accesses to system registers or calibration, muxes the
// responses and answers unmapped regions with an error
`timescale 1ns/1ps

module apb_region_decoder (
  input  rp_pkg::apb_req_t apb_req_i,
  output rp_pkg::apb_rsp_t apb_rsp_o,
  output rp_pkg::apb_req_t regs_req_o,
  input  rp_pkg::apb_rsp_t regs_rsp_i,
  output rp_pkg::apb_req_t clb_req_o,
  input  rp_pkg::apb_rsp_t clb_rsp_i
);

  rp_pkg::region_t  region;
  logic             sel_regs;
  logic             sel_clb;
  rp_pkg::apb_rsp_t err_rsp;

  // Region from top address bits
  assign region = apb_req_i.paddr[rp_pkg::APB_AW-1:rp_pkg::APB_OW];

  always_comb begin
    sel_regs = 1'b0;
    sel_clb  = 1'b0;
    case (region)
      rp_pkg::REG_ID, rp_pkg::REG_PDM,
      rp_pkg::REG_DAC, rp_pkg::REG_ADC: sel_regs = 1'b1;
      rp_pkg::REG_CLB:                  sel_clb  = 1'b1;
      default: ;
    endcase
  end

  // Same request to both, psel only for the chosen one
  always_comb begin
    regs_req_o      = apb_req_i;
    regs_req_o.psel = apb_req_i.psel & sel_regs;
    clb_req_o       = apb_req_i;
    clb_req_o.psel  = apb_req_i.psel & sel_clb;
  end

  // Unmapped region, zero data with error in access phase
  assign err_rsp.prdata  = '0;
  assign err_rsp.pready  = apb_req_i.psel & apb_req_i.penable;
  assign err_rsp.pslverr = apb_req_i.psel & apb_req_i.penable;

  assign apb_rsp_o = sel_clb  ? clb_rsp_i  :
                     sel_regs ? regs_rsp_i : err_rsp;

endmodule

//--- source/rp_top.sv
// Top level of the two-channel ADC/DAC data path
// ADC capture, calibration, DAC interleave, system registers,
// PDM outputs and APB region decoding
`timescale 1ns/1ps

module rp_top (
  input  logic                                           adc_clk,
  input  logic                                           top_rst,
  // APB control port
  input  rp_pkg::apb_req_t                               apb_req_i,
  output rp_pkg::apb_rsp_t                               apb_rsp_o,
  // Raw ADC words, negative slope
  input  logic [rp_pkg::CHN_NUM-1:0][rp_pkg::ADC_DW-1:0] adc_dat_i,
  // Interleaved DAC bus
  output rp_pkg::dac_code_t                              dac_dat_o,
  output logic                                           dac_sel_o,
  // Auxiliary analog outputs
  output logic [rp_pkg::PDM_NUM-1:0]                     pdm_o
);

  ////////////////////////////////////////////////////////////
  // Local signals
  ////////////////////////////////////////////////////////////

  // Slave buses behind the decoder
  rp_pkg::apb_req_t regs_req;
  rp_pkg::apb_rsp_t regs_rsp;
  rp_pkg::apb_req_t clb_req;
  rp_pkg::apb_rsp_t clb_rsp;

  // Sample streams, always valid
  rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0] adc_raw;
  rp_pkg::adc_t [rp_pkg::CHN_NUM-1:0] adc_cal;
  rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0] dac_lvl;
  rp_pkg::dac_t [rp_pkg::CHN_NUM-1:0] dac_cal;

  // PDM level settings
  rp_pkg::pdm_t [rp_pkg::PDM_NUM-1:0] pdm_lvl;

  ////////////////////////////////////////////////////////////
  // APB decoding
  ////////////////////////////////////////////////////////////

  apb_region_decoder u_decoder (
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o),
    .regs_req_o (regs_req),
    .regs_rsp_i (regs_rsp),
    .clb_req_o  (clb_req),
    .clb_rsp_i  (clb_rsp)
  );

  ////////////////////////////////////////////////////////////
  // Sample path
  ////////////////////////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .adc_o     (adc_raw)
  );

  // Offsets on both directions
  calib u_calib (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .apb_req_i (clb_req),
    .apb_rsp_o (clb_rsp),
    .adc_i     (adc_raw),
    .adc_o     (adc_cal),
    .dac_i     (dac_lvl),
    .dac_o     (dac_cal)
  );

  dac_backend u_dac (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .dac_i     (dac_cal),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o)
  );

  ////////////////////////////////////////////////////////////
  // Registers and PDM
  ////////////////////////////////////////////////////////////

  sys_regs u_regs (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .apb_req_i (regs_req),
    .apb_rsp_o (regs_rsp),
    .adc_i     (adc_cal),
    .dac_o     (dac_lvl),
    .pdm_o     (pdm_lvl)
  );

  pdm u_pdm (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .level_i (pdm_lvl),
    .pdm_o   (pdm_o)
  );

endmodule

//--- dv/rp_tb_tasks.svh
// APB master tasks for the testbench
// Reference model of ADC conversion, offset saturation, DAC code and interleave
// Value check built on an immediate assertion
`ifndef RP_TB_TASKS_SVH
`define RP_TB_TASKS_SVH

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

// Region on top, byte offset below
function automatic rp_pkg::apb_addr_t reg_addr(input rp_pkg::region_t region, input int ofs);
  return {region, ofs[15:0]};
endfunction

// Uniform value over the full signed range of a width
function automatic int rand_signed(input int width);
  int v;
  v = int'($urandom_range(0, (1 << width) - 1));
  if (v >= (1 << (width - 1))) v -= (1 << width);
  return v;
endfunction

// Negative slope, so only the magnitude bits flip
function automatic int adc_from_raw(input logic [15:0] raw);
  logic [15:0] tc;
  tc = raw ^ 16'h7FFF;
  return int'($signed(tc));
endfunction

// Clamp to the limits of a signed width
function automatic int sat_add(input int smp, input int ofs, input int width);
  int hi;
  int lo;
  int sum;
  hi  = (1 << (width - 1)) - 1;
  lo  = -(1 << (width - 1));
  sum = smp + ofs;
  if (sum > hi) return hi;
  if (sum < lo) return lo;
  return sum;
endfunction

// Zero sample lands on mid scale
function automatic logic [13:0] dac_code_of(input int smp);
  logic [13:0] tc;
  tc = smp[13:0];
  return tc ^ 14'h1FFF;
endfunction

// Select low carries channel 0
function automatic logic [13:0] bus_expect(input logic sel, input int c0, input int c1);
  return dac_code_of(sel ? c1 : c0);
endfunction

////////////////////////////////////////////////////////////
// Checks and bus access
////////////////////////////////////////////////////////////

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
  assert (got === exp) else report_fail(what, got, exp);
endtask

// Setup cycle, then access cycle sampled well before the rising edge
task automatic read_reg(input rp_pkg::apb_addr_t addr, output rp_pkg::apb_data_t data,
                        output logic err);
  @(negedge adc_clk);
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = 1'b0;
  apb_req.paddr   = addr;
  apb_req.pwdata  = '0;
  @(negedge adc_clk);
  apb_req.penable = 1'b1;
  #(CLK_PERIOD / 4);
  check_value({31'b0, apb_rsp.pready}, 32'd1, "pready in read access");
  data = apb_rsp.prdata;
  err  = apb_rsp.pslverr;
  @(negedge adc_clk);
  apb_req = '0;
endtask

// Write lands on the rising edge that closes the access cycle
task automatic write_reg(input rp_pkg::apb_addr_t addr, input rp_pkg::apb_data_t data);
  @(negedge adc_clk);
  apb_req.psel    = 1'b1;
  apb_req.penable = 1'b0;
  apb_req.pwrite  = 1'b1;
  apb_req.paddr   = addr;
  apb_req.pwdata  = data;
  @(negedge adc_clk);
  apb_req.penable = 1'b1;
  #(CLK_PERIOD / 4);
  check_value({31'b0, apb_rsp.pready}, 32'd1, "pready in write access");
  check_value({31'b0, apb_rsp.pslverr}, 32'd0, "pslverr in write access");
  @(negedge adc_clk);
  apb_req = '0;
endtask

task automatic read_expect(input rp_pkg::apb_addr_t addr, input rp_pkg::apb_data_t exp,
                           input string what);
  rp_pkg::apb_data_t data;
  logic              err;
  read_reg(addr, data, err);
  check_value({31'b0, err}, 32'd0, {what, " pslverr"});
  check_value(data, exp, what);
endtask

`endif

//--- dv/rp_top_tb.sv
// Testbench for the ADC/DAC data path top level
// Clock, reset, watchdog, APB stimulus and assertion checks
`timescale 1ns/1ps

module rp_top_tb;

  localparam int CLK_PERIOD = 100;
  localparam int SEED       = 72614;
  localparam int N_RAND     = 8;

  // Cycle budget with one APB access at about 3 cycles
  localparam int ACC_CYCLES      = 3;
  localparam int CASE_CYCLES     = 8 * ACC_CYCLES + 10;
  localparam int PDM_CYCLES      = 8 * ACC_CYCLES + 260;
  localparam int TEST_CYCLES     = 20 + (N_RAND + 2) * 2 * CASE_CYCLES + PDM_CYCLES;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  logic                                           adc_clk;
  logic                                           top_rst;
  rp_pkg::apb_req_t                               apb_req;
  rp_pkg::apb_rsp_t                               apb_rsp;
  logic [rp_pkg::CHN_NUM-1:0][rp_pkg::ADC_DW-1:0] adc_dat;
  rp_pkg::dac_code_t                              dac_dat;
  logic                                           dac_sel;
  logic [rp_pkg::PDM_NUM-1:0]                     pdm;

  rp_top DUT (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .adc_dat_i (adc_dat),
    .dac_dat_o (dac_dat),
    .dac_sel_o (dac_sel),
    .pdm_o     (pdm)
  );

  task automatic report_fail(input string what, input logic [31:0] got, input logic [31:0] exp);
    $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
    $display("*** FAILED ***");
    $fatal(1, "Value check failed");
  endtask

  `include "rp_tb_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within the watchdog time");
    $display("*** FAILED ***");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Test cases
  ////////////////////////////////////////////////////////////

  // Raw words held while offsets are written, then calibrated readback
  task automatic adc_path_test(input logic [15:0] raw0, input logic [15:0] raw1,
                               input int ofs0, input int ofs1);
    int exp0;
    int exp1;
    @(negedge adc_clk);
    adc_dat[0] = raw0;
    adc_dat[1] = raw1;
    write_reg(reg_addr(rp_pkg::REG_CLB, 0), 32'(ofs0));
    write_reg(reg_addr(rp_pkg::REG_CLB, 4), 32'(ofs1));
    read_expect(reg_addr(rp_pkg::REG_CLB, 0), 32'(ofs0), "ADC offset 0 readback");
    read_expect(reg_addr(rp_pkg::REG_CLB, 4), 32'(ofs1), "ADC offset 1 readback");
    // Two-cycle path long settled by now
    repeat (2) @(negedge adc_clk);
    exp0 = sat_add(adc_from_raw(raw0), ofs0, rp_pkg::ADC_DW);
    exp1 = sat_add(adc_from_raw(raw1), ofs1, rp_pkg::ADC_DW);
    read_expect(reg_addr(rp_pkg::REG_ADC, 0), 32'(exp0), "ADC channel 0 sample");
    read_expect(reg_addr(rp_pkg::REG_ADC, 4), 32'(exp1), "ADC channel 1 sample");
  endtask

  // Levels and offsets written before a few interleaved bus cycles
  task automatic dac_path_test(input int lvl0, input int lvl1, input int ofs0, input int ofs1);
    int   exp0;
    int   exp1;
    logic prev_sel;
    write_reg(reg_addr(rp_pkg::REG_DAC, 0), 32'(lvl0));
    write_reg(reg_addr(rp_pkg::REG_DAC, 4), 32'(lvl1));
    write_reg(reg_addr(rp_pkg::REG_CLB, 8), 32'(ofs0));
    write_reg(reg_addr(rp_pkg::REG_CLB, 12), 32'(ofs1));
    read_expect(reg_addr(rp_pkg::REG_DAC, 0), 32'(lvl0), "DAC level 0 readback");
    read_expect(reg_addr(rp_pkg::REG_DAC, 4), 32'(lvl1), "DAC level 1 readback");
    read_expect(reg_addr(rp_pkg::REG_CLB, 8), 32'(ofs0), "DAC offset 0 readback");
    read_expect(reg_addr(rp_pkg::REG_CLB, 12), 32'(ofs1), "DAC offset 1 readback");
    repeat (2) @(negedge adc_clk);
    exp0     = sat_add(lvl0, ofs0, rp_pkg::DAC_DW);
    exp1     = sat_add(lvl1, ofs1, rp_pkg::DAC_DW);
    prev_sel = dac_sel;
    repeat (4) begin
      @(negedge adc_clk);
      check_value({31'b0, dac_sel}, {31'b0, ~prev_sel}, "DAC select toggle");
      check_value(32'(dac_dat), 32'(bus_expect(dac_sel, exp0, exp1)), "DAC bus code");
      prev_sel = dac_sel;
    end
  endtask

  // High count over one 256-cycle window per channel
  task automatic pdm_density_test();
    int lvl [rp_pkg::PDM_NUM];
    int cnt [rp_pkg::PDM_NUM];
    for (int i = 0; i < rp_pkg::PDM_NUM; i++) begin
      lvl[i] = int'($urandom_range(0, 255));
      cnt[i] = 0;
      write_reg(reg_addr(rp_pkg::REG_PDM, 4 * i), 32'(lvl[i]));
    end
    for (int i = 0; i < rp_pkg::PDM_NUM; i++) begin
      read_expect(reg_addr(rp_pkg::REG_PDM, 4 * i), 32'(lvl[i]), "PDM level readback");
    end
    // Settling cycle
    @(negedge adc_clk);
    repeat (256) begin
      @(negedge adc_clk);
      for (int i = 0; i < rp_pkg::PDM_NUM; i++) cnt[i] += int'(pdm[i]);
    end
    for (int i = 0; i < rp_pkg::PDM_NUM; i++) begin
      check_value(32'(cnt[i]), 32'(lvl[i]), "PDM high count");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rp_pkg::apb_data_t rdata;
    logic              err;
    apb_req = '0;
    adc_dat = '0;
    top_rst = 1'b1;
    void'($urandom(SEED));
    // Two rising edges in reset, release on a falling edge
    repeat (2) @(posedge adc_clk);
    @(negedge adc_clk);
    top_rst = 1'b0;

    // Idle state on both select phases
    check_value({31'b0, dac_sel}, 32'd0, "select after reset");
    check_value(32'(dac_dat), 32'(rp_pkg::DAC_IDLE), "DAC idle, channel 0 phase");
    check_value(32'(pdm), 32'd0, "PDM outputs after reset");
    check_value({31'b0, apb_rsp.pready}, 32'd0, "pready with psel low");
    @(negedge adc_clk);
    check_value({31'b0, dac_sel}, 32'd1, "select second phase");
    check_value(32'(dac_dat), 32'(rp_pkg::DAC_IDLE), "DAC idle, channel 1 phase");

    // ID is read-only and unused offsets read zero
    read_expect(reg_addr(rp_pkg::REG_ID, 0), rp_pkg::ID_VALUE, "ID register");
    read_expect(reg_addr(rp_pkg::REG_ID, 4), 32'd0, "unused ID offset");
    write_reg(reg_addr(rp_pkg::REG_ID, 0), 32'hFFFF_FFFF);
    read_expect(reg_addr(rp_pkg::REG_ID, 0), rp_pkg::ID_VALUE, "ID after write");

    // Unmapped region 2
    read_reg(reg_addr(rp_pkg::region_t'(2), 0), rdata, err);
    check_value({31'b0, err}, 32'd1, "pslverr on region 2");
    check_value(rdata, 32'd0, "prdata on region 2");

    for (int n = 0; n < N_RAND; n++) begin
      adc_path_test(16'($urandom), 16'($urandom), rand_signed(16), rand_signed(16));
      dac_path_test(rand_signed(14), rand_signed(14), rand_signed(14), rand_signed(14));
    end

    // Clamp at the top and then at the bottom
    adc_path_test(16'h0000, 16'h02FF, 32767, 1000);
    dac_path_test(8191, 8000, 8191, 500);
    adc_path_test(16'hFFFF, 16'h8000, -1, -32768);
    dac_path_test(-8192, -1, -1, -8192);

    pdm_density_test();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- rp_top.f
+incdir+dv
source/rp_pkg.sv
source/adc_frontend.sv
source/calib.sv
source/dac_backend.sv
source/sys_regs.sv
source/pdm.sv
source/apb_region_decoder.sv
source/rp_top.sv
dv/rp_top_tb.sv

//--- sim.sh
#!/bin/sh
# Build and run the rp_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module rp_top_tb \
  -f rp_top.f \
  -o rp_top_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/rp_top_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi

exit 0
